// ==== logic/panel_pkg.sv ====
package panel_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus and payload widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [7:0] panel_data_t;
	typedef logic [3:0] digit_t;
	typedef logic [2:0] digit_idx_t;
	typedef logic [3:0] key_code_t;
	typedef logic [1:0] key_col_t;
	typedef logic [7:0] ms_addr_t;
	typedef logic [7:0] ms_data_t;

	// Frame steps in the board's 3-bit encoding
	typedef enum logic [2:0] {
		NONE        = 3'd0,
		CATHODES    = 3'd1,
		ANODES      = 3'd2,
		KEYBOARD_WR = 3'd3,
		MC_ADDR     = 3'd4,
		MC_DATA     = 3'd5,
		KEYBOARD_RD = 3'd6,
		STOP        = 3'd7
	} seq_state_t;

	localparam int NUM_DIGITS = 6;
	localparam panel_data_t ANODE_BLANK = 8'h00;

	// The lowest bus peer index wins
	localparam int NUM_PEERS   = 3;
	localparam int PEER_NIXIE  = 0;
	localparam int PEER_KEYPAD = 1;
	localparam int PEER_MS6205 = 2;

endpackage

// ==== logic/panel_bus_if.sv ====
`timescale 1ns/1ns

interface panel_bus_if;
	import panel_pkg::*;

	// Current frame step
	seq_state_t seq_state;

	// One request bit and one data slot per peer
	wire [NUM_PEERS-1:0] req;
	wire panel_data_t data [NUM_PEERS];

	// Arbiter result
	logic [NUM_PEERS-1:0] gnt;
	panel_data_t bus_data;

	modport sequencer (
		output seq_state
	);

	modport peer (
		input  seq_state,
		input  gnt,
		output req,
		output data
	);

	modport arbiter (
		input  req,
		input  data,
		output gnt,
		output bus_data
	);

endinterface

// ==== logic/panel_sequencer.sv ====
`timescale 1ns/1ns

module panel_sequencer (
	input  logic Clock_1us,
	input  logic Rst_n,
	input  logic scan_enable,
	input  logic addr_acq,
	input  logic data_acq,
	panel_bus_if.sequencer bus,
	output logic cathode_latch,
	output logic anode_latch,
	output logic key_col_latch,
	output logic key_row_rd,
	output logic ms_addr_go,
	output logic ms_data_go
);
	import panel_pkg::*;

	seq_state_t state_q;
	seq_state_t state_d;
	logic       data_pend_q;

	assign bus.seq_state = state_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next step
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Each write step holds until its own strobe has been out for a cycle
	always_comb begin
		state_d = state_q;
		case (state_q)
			NONE:
				state_d = scan_enable ? CATHODES : NONE;
			CATHODES:
				state_d = cathode_latch ? ANODES : CATHODES;
			ANODES:
				state_d = anode_latch ? KEYBOARD_WR : ANODES;
			KEYBOARD_WR: begin
				// Pending MS6205 work is decided here once per frame
				if (key_col_latch) begin
					if (addr_acq)
						state_d = MC_ADDR;
					else if (data_acq)
						state_d = MC_DATA;
					else
						state_d = STOP;
				end
			end
			MC_ADDR: begin
				if (ms_addr_go)
					state_d = data_pend_q ? MC_DATA : STOP;
			end
			MC_DATA:
				state_d = ms_data_go ? STOP : MC_DATA;
			STOP:
				state_d = scan_enable ? STOP : KEYBOARD_RD;
			KEYBOARD_RD:
				state_d = key_row_rd ? NONE : KEYBOARD_RD;
			default:
				state_d = NONE;
		endcase
	end

	always_ff @(posedge Clock_1us or negedge Rst_n) begin
		if (!Rst_n) begin
			state_q     <= NONE;
			data_pend_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Data step kept from the end of the column write
			if ((state_q == KEYBOARD_WR) && key_col_latch)
				data_pend_q <= data_acq;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Strobes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One cycle wide in the second cycle of the step
	always_ff @(posedge Clock_1us or negedge Rst_n) begin
		if (!Rst_n) begin
			cathode_latch <= 1'b0;
			anode_latch   <= 1'b0;
			key_col_latch <= 1'b0;
			key_row_rd    <= 1'b0;
			ms_addr_go    <= 1'b0;
			ms_data_go    <= 1'b0;
		end else begin
			cathode_latch <= (state_q == CATHODES) & scan_enable & ~cathode_latch;
			// Anodes also latched blank during the key read
			anode_latch   <= (((state_q == ANODES) & scan_enable) |
			                  ((state_q == KEYBOARD_RD) & ~scan_enable)) & ~anode_latch;
			key_col_latch <= (state_q == KEYBOARD_WR) & scan_enable & ~key_col_latch;
			key_row_rd    <= (state_q == KEYBOARD_RD) & ~scan_enable & ~key_row_rd;
			ms_addr_go    <= (state_q == MC_ADDR) & scan_enable & ~ms_addr_go;
			ms_data_go    <= (state_q == MC_DATA) & scan_enable & ~ms_data_go;
		end
	end

endmodule

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter (
	input  logic Clock_1us,
	input  logic Rst_n,
	panel_bus_if.arbiter bus,
	output panel_pkg::panel_data_t panel_data,
	output logic bus_conflict
);
	import panel_pkg::*;

	logic [NUM_PEERS-1:0] gnt;

	// Fixed priority with the lowest peer index first
	always_comb begin
		gnt = '0;
		if (bus.req[PEER_NIXIE])
			gnt[PEER_NIXIE] = 1'b1;
		else if (bus.req[PEER_KEYPAD])
			gnt[PEER_KEYPAD] = 1'b1;
		else if (bus.req[PEER_MS6205])
			gnt[PEER_MS6205] = 1'b1;
	end

	// Idle bus reads as zero
	always_comb begin
		bus.bus_data = '0;
		for (int i = 0; i < NUM_PEERS; i++) begin
			if (gnt[i])
				bus.bus_data = bus.data[i];
		end
	end

	assign bus.gnt    = gnt;
	assign panel_data = bus.bus_data;

	// Two owners in one step mean a sequencing fault and the flag stays set
	always_ff @(posedge Clock_1us or negedge Rst_n) begin
		if (!Rst_n) begin
			bus_conflict <= 1'b0;
		end else if ($countones(bus.req) > 1) begin
			bus_conflict <= 1'b1;
		end
	end

endmodule

// ==== logic/nixie_scan.sv ====
`timescale 1ns/1ns

module nixie_scan (
	input  logic Clock_1us,
	input  logic Rst_n,
	input  logic digit_we,
	input  panel_pkg::digit_idx_t digit_idx,
	input  panel_pkg::digit_t digit_val,
	input  logic anode_latch,
	panel_bus_if.peer bus
);
	import panel_pkg::*;

	digit_t      digits [NUM_DIGITS];
	digit_idx_t  anode_idx;
	panel_data_t drive;
	logic        owns_step;

	// Host digit writes ignore an out of range index
	always_ff @(posedge Clock_1us) begin
		if (digit_we && (digit_idx < digit_idx_t'(NUM_DIGITS)))
			digits[digit_idx] <= digit_val;
	end

	// Moves on once the anode latch has taken this digit
	always_ff @(posedge Clock_1us or negedge Rst_n) begin
		if (!Rst_n) begin
			anode_idx <= '0;
		end else if (anode_latch && (bus.seq_state == ANODES)) begin
			if (anode_idx == digit_idx_t'(NUM_DIGITS - 1))
				anode_idx <= '0;
			else
				anode_idx <= anode_idx + 1'b1;
		end
	end

	always_comb begin
		drive     = '0;
		owns_step = 1'b1;
		case (bus.seq_state)
			CATHODES:    drive = {4'h0, digits[anode_idx]};
			ANODES:      drive = panel_data_t'(1) << anode_idx;
			// Tubes dark while the rows are read
			KEYBOARD_RD: drive = ANODE_BLANK;
			default:     owns_step = 1'b0;
		endcase
	end

	assign bus.req[PEER_NIXIE]  = owns_step;
	assign bus.data[PEER_NIXIE] = bus.gnt[PEER_NIXIE] ? drive : '0;

endmodule

// ==== logic/keypad_scan.sv ====
`timescale 1ns/1ns

module keypad_scan (
	input  logic Clock_1us,
	input  logic Rst_n,
	input  logic key_col_latch,
	input  logic key_row_rd,
	input  logic [3:0] key_rows,
	output panel_pkg::key_code_t key_code,
	output logic key_valid,
	panel_bus_if.peer bus
);
	import panel_pkg::*;

	key_col_t    col_idx;
	key_col_t    read_col;
	logic [3:0]  col_onehot;
	logic [1:0]  row_idx;
	logic        one_low;
	panel_data_t col_byte;

	// Active-low one-hot column in the low nibble
	assign col_onehot = 4'b0001 << col_idx;
	assign col_byte   = {4'h0, ~col_onehot};

	// No key unless exactly one row is low
	always_comb begin
		row_idx = 2'd0;
		one_low = 1'b1;
		case (key_rows)
			4'b1110: row_idx = 2'd0;
			4'b1101: row_idx = 2'd1;
			4'b1011: row_idx = 2'd2;
			4'b0111: row_idx = 2'd3;
			default: one_low = 1'b0;
		endcase
	end

	// read_col remembers the column just latched for the row read
	always_ff @(posedge Clock_1us or negedge Rst_n) begin
		if (!Rst_n) begin
			col_idx   <= '0;
			read_col  <= '0;
			key_valid <= 1'b0;
		end else begin
			if (key_col_latch) begin
				read_col <= col_idx;
				col_idx  <= col_idx + 1'b1;
			end
			key_valid <= key_row_rd & one_low;
		end
	end

	always_ff @(posedge Clock_1us) begin
		if (key_row_rd && one_low)
			key_code <= key_code_t'({read_col, row_idx});
	end

	assign bus.req[PEER_KEYPAD]  = (bus.seq_state == KEYBOARD_WR);
	assign bus.data[PEER_KEYPAD] = bus.gnt[PEER_KEYPAD] ? col_byte : '0;

endmodule

// ==== logic/ms6205_port.sv ====
`timescale 1ns/1ns

module ms6205_port (
	input  logic Clock_1us,
	input  logic Rst_n,
	input  panel_pkg::ms_addr_t ms_addr,
	input  logic ms_addr_we,
	input  panel_pkg::ms_data_t ms_data,
	input  logic ms_data_we,
	input  logic ms_addr_go,
	input  logic ms_data_go,
	output logic addr_acq,
	output logic data_acq,
	output logic ms_addr_wr_n,
	output logic ms_data_wr_n,
	panel_bus_if.peer bus
);
	import panel_pkg::*;

	ms_addr_t    addr_q;
	ms_data_t    data_q;
	logic        addr_go_q;
	logic        data_go_q;
	logic        addr_fire;
	logic        data_fire;
	panel_data_t drive;
	logic        owns_step;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Go strobe to write pulse
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign addr_fire = ms_addr_go & ~addr_go_q;
	assign data_fire = ms_data_go & ~data_go_q;

	always_ff @(posedge Clock_1us or negedge Rst_n) begin
		if (!Rst_n) begin
			addr_go_q    <= 1'b0;
			data_go_q    <= 1'b0;
			ms_addr_wr_n <= 1'b1;
			ms_data_wr_n <= 1'b1;
			addr_acq     <= 1'b0;
			data_acq     <= 1'b0;
		end else begin
			addr_go_q    <= ms_addr_go;
			data_go_q    <= ms_data_go;
			ms_addr_wr_n <= ~addr_fire;
			ms_data_wr_n <= ~data_fire;
			// A fresh host write beats the clear
			if (ms_addr_we)
				addr_acq <= 1'b1;
			else if (addr_fire)
				addr_acq <= 1'b0;
			if (ms_data_we)
				data_acq <= 1'b1;
			else if (data_fire)
				data_acq <= 1'b0;
		end
	end

	always_ff @(posedge Clock_1us) begin
		if (ms_addr_we)
			addr_q <= ms_addr;
		if (ms_data_we)
			data_q <= ms_data;
	end

	// Pulse trails its step by a cycle, so the byte stays out through it
	always_comb begin
		drive     = '0;
		owns_step = 1'b1;
		if (!ms_addr_wr_n)
			drive = addr_q;
		else if (!ms_data_wr_n)
			drive = data_q;
		else if (bus.seq_state == MC_ADDR)
			drive = addr_q;
		else if (bus.seq_state == MC_DATA)
			drive = data_q;
		else
			owns_step = 1'b0;
	end

	assign bus.req[PEER_MS6205]  = owns_step;
	assign bus.data[PEER_MS6205] = bus.gnt[PEER_MS6205] ? drive : '0;

endmodule

// ==== logic/panel_top.sv ====
`timescale 1ns/1ns

module panel_top (
	input  logic Clock_1us,
	input  logic Rst_n,
	input  logic scan_enable,
	input  logic digit_we,
	input  panel_pkg::digit_idx_t digit_idx,
	input  panel_pkg::digit_t digit_val,
	input  panel_pkg::ms_addr_t ms_addr,
	input  logic ms_addr_we,
	input  panel_pkg::ms_data_t ms_data,
	input  logic ms_data_we,
	input  logic [3:0] key_rows,
	output panel_pkg::panel_data_t panel_data,
	output logic cathode_latch,
	output logic anode_latch,
	output logic key_col_latch,
	output logic key_row_rd,
	output logic ms_addr_wr_n,
	output logic ms_data_wr_n,
	output panel_pkg::key_code_t key_code,
	output logic key_valid,
	output logic bus_conflict
);

	logic addr_acq;
	logic data_acq;
	logic ms_addr_go;
	logic ms_data_go;

	panel_bus_if bus_if ();

	// Frame timing
	panel_sequencer u_sequencer (
		.Clock_1us     (Clock_1us),
		.Rst_n         (Rst_n),
		.scan_enable   (scan_enable),
		.addr_acq      (addr_acq),
		.data_acq      (data_acq),
		.bus           (bus_if.sequencer),
		.cathode_latch (cathode_latch),
		.anode_latch   (anode_latch),
		.key_col_latch (key_col_latch),
		.key_row_rd    (key_row_rd),
		.ms_addr_go    (ms_addr_go),
		.ms_data_go    (ms_data_go)
	);

	bus_arbiter u_arbiter (
		.Clock_1us    (Clock_1us),
		.Rst_n        (Rst_n),
		.bus          (bus_if.arbiter),
		.panel_data   (panel_data),
		.bus_conflict (bus_conflict)
	);

	// Bus peers
	nixie_scan u_nixie (
		.Clock_1us   (Clock_1us),
		.Rst_n       (Rst_n),
		.digit_we    (digit_we),
		.digit_idx   (digit_idx),
		.digit_val   (digit_val),
		.anode_latch (anode_latch),
		.bus         (bus_if.peer)
	);

	keypad_scan u_keypad (
		.Clock_1us     (Clock_1us),
		.Rst_n         (Rst_n),
		.key_col_latch (key_col_latch),
		.key_row_rd    (key_row_rd),
		.key_rows      (key_rows),
		.key_code      (key_code),
		.key_valid     (key_valid),
		.bus           (bus_if.peer)
	);

	ms6205_port u_ms6205 (
		.Clock_1us    (Clock_1us),
		.Rst_n        (Rst_n),
		.ms_addr      (ms_addr),
		.ms_addr_we   (ms_addr_we),
		.ms_data      (ms_data),
		.ms_data_we   (ms_data_we),
		.ms_addr_go   (ms_addr_go),
		.ms_data_go   (ms_data_go),
		.addr_acq     (addr_acq),
		.data_acq     (data_acq),
		.ms_addr_wr_n (ms_addr_wr_n),
		.ms_data_wr_n (ms_data_wr_n),
		.bus          (bus_if.peer)
	);

endmodule

// ==== sim/panel_tb.sv ====
`timescale 1ns/1ns

module panel_tb;
	import panel_pkg::*;

	localparam int NUM_FRAMES = 24;
	localparam int WAIT_LIMIT = 200;

	logic        Clock_1us;
	logic        Rst_n;
	logic        scan_enable;
	logic        digit_we;
	digit_idx_t  digit_idx;
	digit_t      digit_val;
	ms_addr_t    ms_addr;
	logic        ms_addr_we;
	ms_data_t    ms_data;
	logic        ms_data_we;
	logic [3:0]  key_rows = 4'hF;
	panel_data_t panel_data;
	logic        cathode_latch;
	logic        anode_latch;
	logic        key_col_latch;
	logic        key_row_rd;
	logic        ms_addr_wr_n;
	logic        ms_data_wr_n;
	key_code_t   key_code;
	logic        key_valid;
	logic        bus_conflict;

	// Reference model state
	logic [31:0] rng;
	digit_t      exp_digits [NUM_DIGITS];
	logic        ms_pending = 1'b0;
	ms_addr_t    exp_addr;
	ms_data_t    exp_data;
	logic        key_down = 1'b0;
	logic [1:0]  key_col = 2'd0;
	logic [1:0]  key_row = 2'd0;
	logic [3:0]  col_nibble = 4'hF;
	logic        valid_due = 1'b0;
	key_code_t   code_due;
	int cyc = 0;
	int frame = 0;
	int cl_cyc = 0;
	int al_cyc = 0;
	int kcl_cyc = 0;
	int krr_cyc = -8;
	int n_kcl = 0;
	int n_krr = 0;
	int n_data_wr = 0;
	int frame_addr_wr = 0;
	int frame_data_wr = 0;

	panel_top uut (.*);

	initial begin
		Clock_1us = 1'b0;
		forever #50 Clock_1us = ~Clock_1us;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic abort_run;
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		abort_run();
	endtask

	// 0 column writes, 1 MS6205 data pulses, 2 row reads
	function automatic int event_count(input int sel);
		case (sel)
			0:       return n_kcl;
			1:       return n_data_wr;
			default: return n_krr;
		endcase
	endfunction

	// Returns on a rising edge
	task automatic wait_for_count(input int sel, input int target, input string what);
		int waited;
		waited = 0;
		do begin
			@(posedge Clock_1us);
			waited++;
			if (waited > WAIT_LIMIT)
				report_timeout(what);
		end while (event_count(sel) < target);
	endtask

	task automatic check_quiet;
		assert (!cathode_latch && !anode_latch && !key_col_latch && !key_row_rd)
			else report_mismatch("strobe high around reset");
		assert (ms_addr_wr_n && ms_data_wr_n)
			else report_mismatch("MS6205 write pulse around reset");
		assert (!key_valid && !bus_conflict)
			else report_mismatch("key_valid or bus_conflict set around reset");
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Key matrix
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge Clock_1us) begin
		if (Rst_n && key_col_latch)
			col_nibble <= panel_data[3:0];
	end

	// Pressed switch pulls its row down while its column is low
	always @(posedge Clock_1us) begin
		#10;
		if (key_down && !col_nibble[key_col])
			key_rows = ~(4'b0001 << key_row);
		else
			key_rows = 4'hF;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Frame monitor
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge Clock_1us) begin
		if (Rst_n) begin
			cyc++;
			if (cathode_latch) begin
				assert (panel_data == {4'h0, exp_digits[frame % NUM_DIGITS]})
					else report_mismatch($sformatf("cathode byte %h in frame %0d",
						panel_data, frame));
				cl_cyc = cyc;
			end
			if (anode_latch && !key_row_rd) begin
				assert (cyc == cl_cyc + 2)
					else report_mismatch("anode_latch not 2 cycles after cathode_latch");
				assert (panel_data == panel_data_t'(8'h01 << (frame % NUM_DIGITS)))
					else report_mismatch($sformatf("anode byte %h in frame %0d",
						panel_data, frame));
				al_cyc = cyc;
			end
			if (key_col_latch) begin
				assert (cyc == al_cyc + 2)
					else report_mismatch("key_col_latch not 2 cycles after anode_latch");
				assert (panel_data == {4'h0, ~(4'b0001 << (frame % 4))})
					else report_mismatch($sformatf("column byte %h in frame %0d",
						panel_data, frame));
				kcl_cyc = cyc;
				n_kcl++;
			end
			// Address pulse 3 cycles after the column write and data 2 cycles later
			if (!ms_addr_wr_n) begin
				assert (ms_pending && cyc == kcl_cyc + 3)
					else report_mismatch("ms_addr_wr_n pulse out of place");
				assert (panel_data == exp_addr)
					else report_mismatch($sformatf("MS6205 address %h, expected %h",
						panel_data, exp_addr));
				frame_addr_wr++;
			end
			if (!ms_data_wr_n) begin
				assert (ms_pending && cyc == kcl_cyc + 5)
					else report_mismatch("ms_data_wr_n pulse out of place");
				assert (panel_data == exp_data)
					else report_mismatch($sformatf("MS6205 data %h, expected %h",
						panel_data, exp_data));
				frame_data_wr++;
				n_data_wr++;
			end
			if (key_row_rd) begin
				assert (anode_latch && panel_data == ANODE_BLANK)
					else report_mismatch("tubes not blanked during key read");
				assert (frame_addr_wr == (ms_pending ? 1 : 0) &&
				        frame_data_wr == (ms_pending ? 1 : 0))
					else report_mismatch($sformatf("%0d address and %0d data pulses",
						frame_addr_wr, frame_data_wr));
				valid_due = key_down && (key_col == 2'(frame % 4));
				code_due  = key_code_t'(4 * int'(key_col) + int'(key_row));
				krr_cyc = cyc;
				n_krr++;
				frame++;
				frame_addr_wr = 0;
				frame_data_wr = 0;
			end
			if (cyc == krr_cyc + 1) begin
				assert (key_valid == valid_due)
					else report_mismatch($sformatf("key_valid %b, expected %b",
						key_valid, valid_due));
				if (valid_due)
					assert (key_code == code_due)
						else report_mismatch($sformatf("key_code %h, expected %h",
							key_code, code_due));
			end else begin
				assert (!key_valid)
					else report_mismatch("key_valid outside the cycle after key_row_rd");
			end
		end
	end

	no_conflict: assert property (@(negedge Clock_1us) disable iff (!Rst_n) !bus_conflict)
		else report_mismatch("bus_conflict set");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		int data_pulses;
		rng         = 32'hec76_20c8;
		data_pulses = 0;
		Rst_n       = 1'b0;
		scan_enable = 1'b0;
		digit_we    = 1'b0;
		digit_idx   = '0;
		digit_val   = '0;
		ms_addr     = '0;
		ms_addr_we  = 1'b0;
		ms_data     = '0;
		ms_data_we  = 1'b0;

		repeat (16) begin
			@(negedge Clock_1us);
			check_quiet();
		end
		@(posedge Clock_1us);
		#10;
		Rst_n = 1'b1;
		repeat (2) begin
			@(negedge Clock_1us);
			check_quiet();
		end

		// Six BCD digits
		for (int i = 0; i < NUM_DIGITS; i++) begin
			@(posedge Clock_1us);
			#10;
			rng = lcg_step(rng);
			digit_we      = 1'b1;
			digit_idx     = digit_idx_t'(i);
			digit_val     = digit_t'(rng[23:16] % 8'd10);
			exp_digits[i] = digit_val;
		end
		@(posedge Clock_1us);
		#10;
		digit_we = 1'b0;

		for (int f = 0; f < NUM_FRAMES; f++) begin
			@(posedge Clock_1us);
			#10;
			rng = lcg_step(rng);
			key_down = rng[8];
			// Even frames press a key in the column being scanned
			key_col    = (f % 2 == 0) ? 2'(f % 4) : rng[11:10];
			key_row    = rng[13:12];
			ms_pending = (f % 3 == 1);
			if (ms_pending) begin
				exp_addr   = rng[31:24];
				rng        = lcg_step(rng);
				exp_data   = rng[31:24];
				ms_addr    = exp_addr;
				ms_data    = exp_data;
				ms_addr_we = 1'b1;
				ms_data_we = 1'b1;
				data_pulses++;
			end
			@(posedge Clock_1us);
			#10;
			ms_addr_we  = 1'b0;
			ms_data_we  = 1'b0;
			scan_enable = 1'b1;
			wait_for_count(0, f + 1, "key_col_latch");
			if (ms_pending)
				wait_for_count(1, data_pulses, "ms_data_wr_n pulse");
			#10;
			scan_enable = 1'b0;
			wait_for_count(2, f + 1, "key_row_rd");
		end
		// Room for the last key_valid check
		@(posedge Clock_1us);
		@(posedge Clock_1us);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== build.f ====
logic/panel_pkg.sv
logic/panel_bus_if.sv
logic/panel_sequencer.sv
logic/bus_arbiter.sv
logic/nixie_scan.sv
logic/keypad_scan.sv
logic/ms6205_port.sv
logic/panel_top.sv
sim/panel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module panel_tb -Mdir obj_dir -o panel_sim -f build.f

status=0
./obj_dir/panel_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation reported a failing check"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi
echo "Simulation finished without failures"
